//--- Bender.yml
package:
  name: fma_unit

sources:
  - hw/fma_pkg.sv
  - hw/fma_align_add.sv
  - hw/fma_pipe_stage.sv
  - hw/fma_norm_round.sv
  - hw/fma_unit.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_fma_unit.sv

//--- fma_unit.f
+incdir+test
hw/fma_pkg.sv
hw/fma_align_add.sv
hw/fma_pipe_stage.sv
hw/fma_norm_round.sv
hw/fma_unit.sv
test/tb_fma_unit.sv

//--- hw/fma_align_add.sv
`default_nettype none

module fma_align_add import fma_pkg::*; (
  input  wire [FP_WIDTH-1:0]          operand_a_i,
  input  wire [FP_WIDTH-1:0]          operand_b_i,
  input  wire [FP_WIDTH-1:0]          operand_c_i,
  input  wire [1:0]                   op_i,
  input  wire                         op_mod_i,
  input  wire [2:0]                   rnd_mode_i,
  output logic                        eff_sub_o,
  output logic signed [EXP_WIDTH-1:0] exp_prod_o,
  output logic signed [EXP_WIDTH-1:0] exp_diff_o,
  output logic signed [EXP_WIDTH-1:0] tent_exp_o,
  output logic [SHAMT_WIDTH-1:0]      add_shamt_o,
  output logic                        sticky_o,
  output logic [SUM_WIDTH-1:0]        sum_o,
  output logic                        final_sign_o,
  output logic [2:0]                  rnd_mode_o,
  output logic                        is_special_o,
  output logic [FP_WIDTH-1:0]         spec_result_o,
  output logic [4:0]                  spec_status_o
);

  // ------------------------------
  // Operation selection
  // ------------------------------
  // Index 0 is A, 1 is B, 2 is C
  fp_word_u opnd [3];

  always_comb begin
    opnd[0].raw = operand_a_i;
    opnd[1].raw = operand_b_i;
    opnd[2].raw = operand_c_i;
    // Modifier flips the addend for every operation
    opnd[2].fields.sign = opnd[2].fields.sign ^ op_mod_i;
    case (op_i)
      // Negated product
      OP_FNMSUB: opnd[0].fields.sign = ~opnd[0].fields.sign;
      // Multiplicand becomes +1.0
      OP_ADD:    opnd[0].raw = FP_WIDTH'(BIAS << MAN_BITS);
      // Zero addend, +0 only under round-down
      OP_MUL:    opnd[2].raw = {rnd_mode_i != RM_RDN, {(FP_WIDTH-1){1'b0}}};
      default: ;
    endcase
  end

  // Operand classes
  logic [2:0] is_zero, is_sub, is_norm, is_inf, is_nan, is_snan;

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      is_zero[i] = (opnd[i].fields.exponent == '0) && (opnd[i].fields.mantissa == '0);
      is_sub[i]  = (opnd[i].fields.exponent == '0) && (opnd[i].fields.mantissa != '0);
      is_norm[i] = (opnd[i].fields.exponent != '0) && !(&opnd[i].fields.exponent);
      is_inf[i]  = (&opnd[i].fields.exponent) && (opnd[i].fields.mantissa == '0);
      is_nan[i]  = (&opnd[i].fields.exponent) && (opnd[i].fields.mantissa != '0);
      // Quiet bit clear means signalling
      is_snan[i] = is_nan[i] && !opnd[i].fields.mantissa[MAN_BITS-1];
    end
  end

  logic prod_sign;

  assign prod_sign = opnd[0].fields.sign ^ opnd[1].fields.sign;
  // Product and addend of opposite sign
  assign eff_sub_o = prod_sign ^ opnd[2].fields.sign;

  // ------------------------------
  // Special cases
  // ------------------------------
  fp_word_u spec_word;

  always_comb begin
    spec_word.raw = QNAN_CANON;
    spec_status_o = '0;
    is_special_o  = 1'b0;
    // inf x 0 is invalid even with a quiet NaN addend
    if ((is_inf[0] && is_zero[1]) || (is_zero[0] && is_inf[1])) begin
      is_special_o         = 1'b1;
      spec_status_o[ST_NV] = 1'b1;
    end else if (|is_nan) begin
      is_special_o         = 1'b1;
      spec_status_o[ST_NV] = |is_snan;
    end else if (|is_inf) begin
      is_special_o = 1'b1;
      if ((is_inf[0] || is_inf[1]) && is_inf[2] && eff_sub_o) begin
        // Opposite infinities cancel
        spec_status_o[ST_NV] = 1'b1;
      end else begin
        spec_word.fields.exponent = '1;
        spec_word.fields.mantissa = '0;
        // Infinite product wins over an infinite addend of the same sign
        spec_word.fields.sign = (is_inf[0] || is_inf[1]) ? prod_sign : opnd[2].fields.sign;
      end
    end
  end

  assign spec_result_o = spec_word.raw;

  // ------------------------------
  // Exponent datapath
  // ------------------------------
  logic signed [EXP_WIDTH-1:0] exp_a, exp_b, exp_c;

  // Subnormals share the exponent of the smallest normal
  assign exp_a = EXP_WIDTH'(opnd[0].fields.exponent) + EXP_WIDTH'(is_sub[0]);
  assign exp_b = EXP_WIDTH'(opnd[1].fields.exponent) + EXP_WIDTH'(is_sub[1]);
  assign exp_c = EXP_WIDTH'(opnd[2].fields.exponent) + EXP_WIDTH'(!is_norm[2]);

  // Zero product pinned to the minimum exponent
  assign exp_prod_o = (is_zero[0] || is_zero[1]) ? EXP_WIDTH'(2 - BIAS)
                    : exp_a + exp_b - EXP_WIDTH'(BIAS);
  assign exp_diff_o = exp_c - exp_prod_o;
  assign tent_exp_o = (exp_diff_o > 0) ? exp_c : exp_prod_o;

  always_comb begin
    if (exp_diff_o <= -2 * PREC_BITS - 1) begin
      // Addend lands entirely in the sticky bits
      add_shamt_o = SHAMT_WIDTH'(SUM_WIDTH);
    end else if (exp_diff_o <= PREC_BITS + 2) begin
      add_shamt_o = SHAMT_WIDTH'(PREC_BITS + 3 - exp_diff_o);
    end else begin
      // Addend anchored, product is only sticky
      add_shamt_o = '0;
    end
  end

  // ------------------------------
  // Multiply, align and add
  // ------------------------------
  logic [PREC_BITS-1:0]   man_a, man_b, man_c;
  logic [2*PREC_BITS-1:0] product;
  logic [SUM_WIDTH-1:0]   product_shifted;
  logic [SUM_WIDTH-1:0]   addend_aligned;
  logic [SUM_WIDTH-1:0]   addend_inv;
  logic [PREC_BITS-1:0]   addend_sticky;
  logic [SUM_WIDTH:0]     sum_raw;
  logic                   carry_in;

  assign man_a = {is_norm[0], opnd[0].fields.mantissa};
  assign man_b = {is_norm[1], opnd[1].fields.mantissa};
  assign man_c = {is_norm[2], opnd[2].fields.mantissa};

  assign product = man_a * man_b;
  // Layout: p+2 zeros, 2p product bits, round and sticky slots
  assign product_shifted = {{(PREC_BITS+2){1'b0}}, product, 2'b00};

  // Up to p bits fall off the bottom into the sticky
  assign {addend_aligned, addend_sticky} = {man_c, {SUM_WIDTH{1'b0}}} >> add_shamt_o;
  assign sticky_o = |addend_sticky;

  // Ones complement, plus one only when nothing was lost
  assign addend_inv = eff_sub_o ? ~addend_aligned : addend_aligned;
  assign carry_in   = eff_sub_o & ~sticky_o;
  assign sum_raw    = product_shifted + addend_inv + carry_in;

  // No carry out on a subtraction means the sum went negative
  assign sum_o = (eff_sub_o && !sum_raw[SUM_WIDTH]) ? -sum_raw[SUM_WIDTH-1:0]
                                                    : sum_raw[SUM_WIDTH-1:0];
  assign final_sign_o = eff_sub_o ? (sum_raw[SUM_WIDTH] == prod_sign) : prod_sign;
  assign rnd_mode_o   = rnd_mode_i;

  // Addend never shifts past the full sum width
  a_shamt_range: assert final (
    $isunknown({operand_a_i, operand_b_i, operand_c_i, op_i, op_mod_i, rnd_mode_i})
    || (add_shamt_o <= SUM_WIDTH));

endmodule

`default_nettype wire

//--- hw/fma_norm_round.sv
`default_nettype none

module fma_norm_round import fma_pkg::*; (
  input  wire                         eff_sub_i,
  input  wire signed [EXP_WIDTH-1:0]  exp_prod_i,
  input  wire signed [EXP_WIDTH-1:0]  exp_diff_i,
  input  wire signed [EXP_WIDTH-1:0]  tent_exp_i,
  input  wire [SHAMT_WIDTH-1:0]       add_shamt_i,
  input  wire                         sticky_i,
  input  wire [SUM_WIDTH-1:0]         sum_i,
  input  wire                         final_sign_i,
  input  wire [2:0]                   rnd_mode_i,
  input  wire                         is_special_i,
  input  wire [FP_WIDTH-1:0]          spec_result_i,
  input  wire [4:0]                   spec_status_i,
  output logic [FP_WIDTH-1:0]         result_o,
  output logic [4:0]                  status_o
);

  // Cancellation can only reach into the lower 2p+3 bits
  localparam int LOWER_WIDTH = 2 * PREC_BITS + 3;
  localparam int LZC_WIDTH   = $clog2(LOWER_WIDTH);

  // ------------------------------
  // Normalization
  // ------------------------------
  logic [LZC_WIDTH-1:0]        lz_cnt;
  logic signed [LZC_WIDTH:0]   lz_cnt_sgn;
  logic                        lz_all_zero;
  logic [SHAMT_WIDTH-1:0]      norm_shamt;
  logic signed [EXP_WIDTH-1:0] norm_exp;
  logic [SUM_WIDTH:0]          sum_shifted;
  logic [PREC_BITS:0]          final_man;
  logic [2*PREC_BITS+2:0]      sticky_bits;
  logic signed [EXP_WIDTH-1:0] final_exp;
  logic                        sticky_after;

  // Highest set bit wins since it is found last
  always_comb begin
    lz_cnt      = '0;
    lz_all_zero = ~|sum_i[LOWER_WIDTH-1:0];
    for (int i = 0; i < LOWER_WIDTH; i++) begin
      if (sum_i[i]) begin
        lz_cnt = LZC_WIDTH'(LOWER_WIDTH - 1 - i);
      end
    end
  end

  assign lz_cnt_sgn = signed'({1'b0, lz_cnt});

  always_comb begin
    if ((exp_diff_i <= 0) || (eff_sub_i && (exp_diff_i <= 2))) begin
      // Product anchored or cancelling
      if ((exp_prod_i - lz_cnt_sgn + 1 >= 0) && !lz_all_zero) begin
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2 + lz_cnt);
        norm_exp   = exp_prod_i - lz_cnt_sgn + 1;
      end else begin
        // Subnormal result, stop at the minimum exponent
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2 + exp_prod_i);
        norm_exp   = '0;
      end
    end else begin
      // Addend anchored, undo the alignment
      norm_shamt = add_shamt_i;
      norm_exp   = tent_exp_i;
    end
  end

  assign sum_shifted = (SUM_WIDTH+1)'(sum_i) << norm_shamt;

  // Leading one may sit one place off the MSB
  always_comb begin
    {final_man, sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    final_exp                = norm_exp;
    if (sum_shifted[SUM_WIDTH]) begin
      {final_man, sticky_bits} = sum_shifted[SUM_WIDTH:1];
      final_exp                = norm_exp + 1;
    end else if (sum_shifted[SUM_WIDTH-1]) begin
      final_exp = norm_exp;
    end else if (norm_exp > 1) begin
      {final_man, sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
      final_exp                = norm_exp - 1;
    end else begin
      final_exp = '0;
    end
  end

  assign sticky_after = (|sticky_bits) | sticky_i;

  // ------------------------------
  // Rounding
  // ------------------------------
  logic                of_before, of_after, uf_after;
  logic [EXP_BITS-1:0] pre_exp;
  logic [MAN_BITS-1:0] pre_man;
  logic [FP_WIDTH-2:0] pre_abs, rounded_abs;
  logic [1:0]          rs_bits;
  logic                round_up, exact_zero, rounded_sign;

  assign of_before = final_exp >= 2 ** EXP_BITS - 1;
  // Overflow starts from the largest finite value with R and S set
  assign pre_exp = of_before ? EXP_BITS'(2 ** EXP_BITS - 2) : final_exp[EXP_BITS-1:0];
  assign pre_man = of_before ? '1 : final_man[MAN_BITS:1];
  assign pre_abs = {pre_exp, pre_man};
  assign rs_bits = of_before ? 2'b11 : {final_man[0], sticky_after};

  always_comb begin
    case (rnd_mode_i)
      RM_RNE:  round_up = rs_bits[1] && (rs_bits[0] || pre_abs[0]);
      RM_RTZ:  round_up = 1'b0;
      RM_RDN:  round_up = (|rs_bits) && final_sign_i;
      RM_RUP:  round_up = (|rs_bits) && !final_sign_i;
      RM_RMM:  round_up = rs_bits[1];
      default: round_up = 1'b0;
    endcase
  end

  // Mantissa carry ripples into the exponent
  assign rounded_abs = pre_abs + (FP_WIDTH-1)'(round_up);
  assign exact_zero  = (pre_abs == '0) && (rs_bits == '0);
  // Exact cancellation is +0 except under round-down
  assign rounded_sign = (exact_zero && eff_sub_i) ? (rnd_mode_i == RM_RDN) : final_sign_i;

  assign of_after = &rounded_abs[FP_WIDTH-2:MAN_BITS];
  // Tiny after rounding, judged as if the exponent range were unbounded
  assign uf_after = (rounded_abs[FP_WIDTH-2:MAN_BITS] == '0)
                 || ((pre_exp == '0) && (rounded_abs[FP_WIDTH-2:MAN_BITS] == EXP_BITS'(1))
                     && ((rs_bits != 2'b11)
                         || (!sticky_bits[2*PREC_BITS+2]
                             && ((rnd_mode_i == RM_RNE) || (rnd_mode_i == RM_RMM)))));

  // ------------------------------
  // Result selection
  // ------------------------------
  fp_word_u   reg_word;
  logic [4:0] reg_status;

  always_comb begin
    reg_word.fields.sign     = rounded_sign;
    reg_word.fields.exponent = rounded_abs[FP_WIDTH-2:MAN_BITS];
    reg_word.fields.mantissa = rounded_abs[MAN_BITS-1:0];
  end

  always_comb begin
    reg_status        = '0;
    reg_status[ST_OF] = of_before | of_after;
    reg_status[ST_NX] = (|rs_bits) | of_before | of_after;
    // UF only when also inexact
    reg_status[ST_UF] = uf_after & reg_status[ST_NX];
  end

  assign result_o = is_special_i ? spec_result_i : reg_word.raw;
  assign status_o = is_special_i ? spec_status_i : reg_status;

  // Invalid comes only from the front end's special-case detection
  a_nv_only_special: assert final (
    $isunknown(is_special_i) || is_special_i || !status_o[ST_NV]);

endmodule

`default_nettype wire

//--- hw/fma_pipe_stage.sv
`default_nettype none

module fma_pipe_stage #(
  parameter int unsigned DataWidth = 1
) (
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  input  wire                  flush_i,
  // Upstream side
  input  wire                  valid_i,
  output logic                 ready_o,
  input  wire [DataWidth-1:0]  data_i,
  // Downstream side
  output logic                 valid_o,
  input  wire                  ready_i,
  output logic [DataWidth-1:0] data_o
);

  logic                 valid_q;
  logic [DataWidth-1:0] data_q;

  // Accept when downstream takes ours or we hold a bubble
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves with a real transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // Stalled item keeps its payload
  a_hold_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> $stable(data_o));

endmodule

`default_nettype wire

//--- hw/fma_pkg.sv
`default_nettype none

package fma_pkg;

  // ------------------------------
  // binary16 format
  // ------------------------------
  localparam int EXP_BITS  = 5;
  localparam int MAN_BITS  = 10;
  localparam int FP_WIDTH  = 1 + EXP_BITS + MAN_BITS;
  localparam int BIAS      = 2 ** (EXP_BITS - 1) - 1;
  // Mantissa including the hidden bit
  localparam int PREC_BITS = MAN_BITS + 1;

  // ------------------------------
  // Internal datapath widths
  // ------------------------------
  // Product, addend overhang, guard and round positions
  localparam int SUM_WIDTH   = 3 * PREC_BITS + 4;
  // Two spare bits keep biased exponents signed without wrap
  localparam int EXP_WIDTH   = EXP_BITS + 2;
  localparam int SHAMT_WIDTH = $clog2(SUM_WIDTH + 1);
  // eff_sub, three exponents, shift, sticky, sum, sign, rounding mode,
  // special flag, special result and special status
  localparam int MID_WIDTH   = 1 + 3 * EXP_WIDTH + SHAMT_WIDTH + 1 + SUM_WIDTH
                             + 1 + 3 + 1 + FP_WIDTH + 5;

  // Operation codes, the modifier negates the addend
  localparam logic [1:0] OP_FMADD  = 2'd0;
  localparam logic [1:0] OP_FNMSUB = 2'd1;
  localparam logic [1:0] OP_ADD    = 2'd2;
  localparam logic [1:0] OP_MUL    = 2'd3;

  // Rounding modes, RISC-V numbering
  localparam logic [2:0] RM_RNE = 3'd0;
  localparam logic [2:0] RM_RTZ = 3'd1;
  localparam logic [2:0] RM_RDN = 3'd2;
  localparam logic [2:0] RM_RUP = 3'd3;
  localparam logic [2:0] RM_RMM = 3'd4;

  // Status word bit positions
  localparam int ST_NV = 4;
  localparam int ST_DZ = 3;
  localparam int ST_OF = 2;
  localparam int ST_UF = 1;
  localparam int ST_NX = 0;

  localparam logic [FP_WIDTH-1:0] QNAN_CANON = 16'h7E00;

  // Same 16 bits seen as a whole word or as its fields
  typedef union packed {
    logic [FP_WIDTH-1:0] raw;
    struct packed {
      logic                sign;
      logic [EXP_BITS-1:0] exponent;
      logic [MAN_BITS-1:0] mantissa;
    } fields;
  } fp_word_u;

endpackage

`default_nettype wire

//--- hw/fma_unit.sv
`default_nettype none

module fma_unit import fma_pkg::*; #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire [FP_WIDTH-1:0]  operand_a_i,
  input  wire [FP_WIDTH-1:0]  operand_b_i,
  input  wire [FP_WIDTH-1:0]  operand_c_i,
  input  wire [1:0]           op_i,
  input  wire                 op_mod_i,
  input  wire [2:0]           rnd_mode_i,
  input  wire                 in_valid_i,
  output logic                in_ready_o,
  input  wire                 flush_i,
  output logic [FP_WIDTH-1:0] result_o,
  output logic [4:0]          status_o,
  output logic                out_valid_o,
  input  wire                 out_ready_i,
  output logic                busy_o
);

  // Front end outputs
  logic                        eff_sub_d, sticky_d, final_sign_d, is_special_d;
  logic signed [EXP_WIDTH-1:0] exp_prod_d, exp_diff_d, tent_exp_d;
  logic [SHAMT_WIDTH-1:0]      add_shamt_d;
  logic [SUM_WIDTH-1:0]        sum_d;
  logic [2:0]                  rnd_mode_d;
  logic [FP_WIDTH-1:0]         spec_result_d;
  logic [4:0]                  spec_status_d;

  // Back end inputs
  logic                        eff_sub_q, sticky_q, final_sign_q, is_special_q;
  logic signed [EXP_WIDTH-1:0] exp_prod_q, exp_diff_q, tent_exp_q;
  logic [SHAMT_WIDTH-1:0]      add_shamt_q;
  logic [SUM_WIDTH-1:0]        sum_q;
  logic [2:0]                  rnd_mode_q;
  logic [FP_WIDTH-1:0]         spec_result_q;
  logic [4:0]                  spec_status_q;

  fma_align_add i_align_add (
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .operand_c_i   (operand_c_i),
    .op_i          (op_i),
    .op_mod_i      (op_mod_i),
    .rnd_mode_i    (rnd_mode_i),
    .eff_sub_o     (eff_sub_d),
    .exp_prod_o    (exp_prod_d),
    .exp_diff_o    (exp_diff_d),
    .tent_exp_o    (tent_exp_d),
    .add_shamt_o   (add_shamt_d),
    .sticky_o      (sticky_d),
    .sum_o         (sum_d),
    .final_sign_o  (final_sign_d),
    .rnd_mode_o    (rnd_mode_d),
    .is_special_o  (is_special_d),
    .spec_result_o (spec_result_d),
    .spec_status_o (spec_status_d)
  );

  // ------------------------------
  // Mid pipeline
  // ------------------------------
  // Index i holds the item after i stages
  logic [NumPipeRegs:0][MID_WIDTH-1:0] pipe_data;
  logic [NumPipeRegs:0]                pipe_valid;
  logic [NumPipeRegs:0]                pipe_ready;

  assign pipe_data[0]  = {eff_sub_d, exp_prod_d, exp_diff_d, tent_exp_d, add_shamt_d,
                          sticky_d, sum_d, final_sign_d, rnd_mode_d, is_special_d,
                          spec_result_d, spec_status_d};
  assign pipe_valid[0] = in_valid_i;
  assign in_ready_o    = pipe_ready[0];

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_pipe
    fma_pipe_stage #(
      .DataWidth (MID_WIDTH)
    ) i_pipe_stage (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .flush_i (flush_i),
      .valid_i (pipe_valid[i]),
      .ready_o (pipe_ready[i]),
      .data_i  (pipe_data[i]),
      .valid_o (pipe_valid[i+1]),
      .ready_i (pipe_ready[i+1]),
      .data_o  (pipe_data[i+1])
    );
  end

  assign pipe_ready[NumPipeRegs] = out_ready_i;
  assign out_valid_o             = pipe_valid[NumPipeRegs];

  assign {eff_sub_q, exp_prod_q, exp_diff_q, tent_exp_q, add_shamt_q, sticky_q, sum_q,
          final_sign_q, rnd_mode_q, is_special_q, spec_result_q, spec_status_q}
         = pipe_data[NumPipeRegs];

  // Nothing in flight without registers
  if (NumPipeRegs == 0) begin : gen_no_busy
    assign busy_o = 1'b0;
  end else begin : gen_busy
    assign busy_o = |pipe_valid[NumPipeRegs:1];
  end

  fma_norm_round i_norm_round (
    .eff_sub_i     (eff_sub_q),
    .exp_prod_i    (exp_prod_q),
    .exp_diff_i    (exp_diff_q),
    .tent_exp_i    (tent_exp_q),
    .add_shamt_i   (add_shamt_q),
    .sticky_i      (sticky_q),
    .sum_i         (sum_q),
    .final_sign_i  (final_sign_q),
    .rnd_mode_i    (rnd_mode_q),
    .is_special_i  (is_special_q),
    .spec_result_i (spec_result_q),
    .spec_status_i (spec_status_q),
    .result_o      (result_o),
    .status_o      (status_o)
  );

endmodule

`default_nettype wire

//--- test/fma_vectors.svh
`ifndef FMA_VECTORS_SVH
`define FMA_VECTORS_SVH

// Each row is op code, modifier, rounding mode, operands A B C,
// then the expected result and the expected status word (NV DZ OF UF NX)
localparam int NUM_VECTORS = 25;
localparam int VEC_WIDTH   = 2 + 1 + 3 + 4 * FP_WIDTH + 5;

localparam logic [VEC_WIDTH-1:0] VECTORS [NUM_VECTORS] = '{
  // Exact fused forms on 2 x 3 with addend 1
  {OP_FMADD,  1'b0, RM_RNE, 16'h4000, 16'h4200, 16'h3C00, 16'h4700, 5'h00},
  {OP_FMADD,  1'b1, RM_RNE, 16'h4000, 16'h4200, 16'h3C00, 16'h4500, 5'h00},
  {OP_FNMSUB, 1'b0, RM_RNE, 16'h4000, 16'h4200, 16'h3C00, 16'hC500, 5'h00},
  {OP_FNMSUB, 1'b1, RM_RNE, 16'h4000, 16'h4200, 16'h3C00, 16'hC700, 5'h00},
  // 1.5 x 0.5 + 2.5 is 3.25
  {OP_FMADD,  1'b0, RM_RNE, 16'h3E00, 16'h3800, 16'h4100, 16'h4280, 5'h00},
  // Operand A is an infinity that ADD must ignore
  {OP_ADD,    1'b0, RM_RNE, 16'h7C00, 16'h4100, 16'h3E00, 16'h4400, 5'h00},
  {OP_ADD,    1'b1, RM_RNE, 16'h7C00, 16'h4100, 16'h3E00, 16'h3C00, 5'h00},
  // MUL ignores a NaN addend, 3 x 2.5 is 7.5
  {OP_MUL,    1'b0, RM_RNE, 16'h4200, 16'h4100, 16'h7E00, 16'h4780, 5'h00},
  // Zero products keep the product sign in every mode
  {OP_MUL,    1'b0, RM_RNE, 16'h4200, 16'h8000, 16'h0000, 16'h8000, 5'h00},
  {OP_MUL,    1'b0, RM_RNE, 16'h4200, 16'h0000, 16'h0000, 16'h0000, 5'h00},
  {OP_MUL,    1'b0, RM_RDN, 16'h4200, 16'h0000, 16'h0000, 16'h0000, 5'h00},
  {OP_MUL,    1'b0, RM_RDN, 16'h4200, 16'h8000, 16'h0000, 16'h8000, 5'h00},
  // Negative tie halfway between 0xBE04 and 0xBE05
  {OP_MUL,    1'b0, RM_RNE, 16'hBC03, 16'h3E00, 16'h0000, 16'hBE04, 5'h01},
  {OP_MUL,    1'b0, RM_RTZ, 16'hBC03, 16'h3E00, 16'h0000, 16'hBE04, 5'h01},
  {OP_MUL,    1'b0, RM_RDN, 16'hBC03, 16'h3E00, 16'h0000, 16'hBE05, 5'h01},
  {OP_MUL,    1'b0, RM_RUP, 16'hBC03, 16'h3E00, 16'h0000, 16'hBE04, 5'h01},
  {OP_MUL,    1'b0, RM_RMM, 16'hBC03, 16'h3E00, 16'h0000, 16'hBE05, 5'h01},
  // inf x 0, quiet NaN, signalling NaN, inf - inf
  {OP_FMADD,  1'b0, RM_RNE, 16'h7C00, 16'h0000, 16'h3C00, 16'h7E00, 5'h10},
  {OP_FMADD,  1'b0, RM_RNE, 16'h7E55, 16'h3C00, 16'h3C00, 16'h7E00, 5'h00},
  {OP_FMADD,  1'b0, RM_RNE, 16'h3C00, 16'h3C00, 16'h7D00, 16'h7E00, 5'h10},
  {OP_FMADD,  1'b0, RM_RNE, 16'h7C00, 16'h3C00, 16'hFC00, 16'h7E00, 5'h10},
  // Infinite product times -2 stays infinite
  {OP_FMADD,  1'b0, RM_RNE, 16'h7C00, 16'hC000, 16'h3C00, 16'hFC00, 5'h00},
  // 256 x 256 overflows
  {OP_MUL,    1'b0, RM_RNE, 16'h5C00, 16'h5C00, 16'h0000, 16'h7C00, 5'h05},
  {OP_MUL,    1'b0, RM_RTZ, 16'h5C00, 16'h5C00, 16'h0000, 16'h7BFF, 5'h05},
  // 1.5 ulp of the smallest subnormal rounds to 2 ulp
  {OP_MUL,    1'b0, RM_RNE, 16'h0003, 16'h3800, 16'h0000, 16'h0002, 5'h03}
};

`endif

//--- test/tb_fma_unit.sv
`default_nettype none

module tb_fma_unit import fma_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_PIPE_REGS = 2;
  localparam int CLK_PERIOD    = 10;
  localparam int WAIT_LIMIT    = 1000;
  // Modes of the out_ready_i driver
  localparam int READY_HIGH    = 0;
  localparam int READY_LOW     = 1;
  localparam int READY_RANDOM  = 2;

  `include "fma_vectors.svh"

  logic                clk_i;
  logic                rst_n_i;
  logic [FP_WIDTH-1:0] operand_a_i;
  logic [FP_WIDTH-1:0] operand_b_i;
  logic [FP_WIDTH-1:0] operand_c_i;
  logic [1:0]          op_i;
  logic                op_mod_i;
  logic [2:0]          rnd_mode_i;
  logic                in_valid_i;
  logic                in_ready_o;
  logic                flush_i;
  logic [FP_WIDTH-1:0] result_o;
  logic [4:0]          status_o;
  logic                out_valid_o;
  logic                out_ready_i;
  logic                busy_o;

  // Bookkeeping shared by driver and monitor
  int          error_cnt;
  int          check_cnt;
  int          test_cnt;
  int          result_cnt;
  int          cycle_cnt;
  int          drive_idx;
  bit          check_latency;
  int          ready_mode;
  logic [31:0] lcg_state;
  // Row index and acceptance cycle of every item in flight
  int          idx_q[$];
  int          accept_q[$];

  fma_unit #(
    .NumPipeRegs (NUM_PIPE_REGS)
  ) i_fma_unit (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_c_i (operand_c_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .rnd_mode_i  (rnd_mode_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected result and status columns of a row
  function automatic logic [FP_WIDTH-1:0] row_result(input int idx);
    return VECTORS[idx][20:5];
  endfunction

  function automatic logic [4:0] row_status(input int idx);
    return VECTORS[idx][4:0];
  endfunction

  // ------------------------------
  // Output back-pressure
  // ------------------------------
  always @(negedge clk_i) begin
    case (ready_mode)
      READY_LOW: out_ready_i = 1'b0;
      READY_RANDOM: begin
        lcg_state   = lcg_next(lcg_state);
        out_ready_i = lcg_state[16];
      end
      default: out_ready_i = 1'b1;
    endcase
  end

  // ------------------------------
  // Monitor
  // ------------------------------
  // Transfers are sampled at the rising edge where they happen
  always @(posedge clk_i) begin
    int idx;
    int latency;
    if (rst_n_i) begin
      cycle_cnt++;
      if (out_valid_o && out_ready_i) begin
        result_cnt++;
        if (idx_q.size() == 0) begin
          $display("unexpected result 0x%h with no item in flight", result_o);
          error_cnt++;
        end else begin
          idx     = idx_q.pop_front();
          latency = cycle_cnt - accept_q.pop_front();
          check_cnt += 2;
          if (result_o !== row_result(idx)) begin
            $display("ERROR result_o row %0d: expected 0x%h, actual 0x%h",
                     idx, row_result(idx), result_o);
            error_cnt++;
          end
          if (status_o !== row_status(idx)) begin
            $display("ERROR status_o row %0d: expected 0x%h, actual 0x%h",
                     idx, row_status(idx), status_o);
            error_cnt++;
          end
          if (check_latency && (latency != NUM_PIPE_REGS)) begin
            $display("row %0d came out %0d cycles after acceptance instead of %0d",
                     idx, latency, NUM_PIPE_REGS);
            error_cnt++;
          end
        end
      end
      // Flushed items never come out
      if (flush_i) begin
        idx_q.delete();
        accept_q.delete();
      end else if (in_valid_i && in_ready_o) begin
        idx_q.push_back(drive_idx);
        accept_q.push_back(cycle_cnt);
      end
    end
  end

  // ------------------------------
  // Driver tasks
  // ------------------------------
  // Starts and ends on a falling edge, valid stays high for a following item
  task automatic send_item(input int idx);
    int waited;
    op_i        = VECTORS[idx][74:73];
    op_mod_i    = VECTORS[idx][72];
    rnd_mode_i  = VECTORS[idx][71:69];
    operand_a_i = VECTORS[idx][68:53];
    operand_b_i = VECTORS[idx][52:37];
    operand_c_i = VECTORS[idx][36:21];
    drive_idx   = idx;
    in_valid_i  = 1'b1;
    waited      = 0;
    @(posedge clk_i);
    while (!in_ready_o && (waited < WAIT_LIMIT)) begin
      waited++;
      @(posedge clk_i);
    end
    if (!in_ready_o) begin
      $display("timeout while row %0d waited to be accepted", idx);
      error_cnt++;
    end
    @(negedge clk_i);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((idx_q.size() != 0) && (waited < WAIT_LIMIT)) begin
      waited++;
      @(negedge clk_i);
    end
    if (idx_q.size() != 0) begin
      $display("timeout with %0d results still missing", idx_q.size());
      error_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    test_cnt++;
    if (error_cnt == errors_before) begin
      $display("test %s ok", name);
    end else begin
      $display("test %s had %0d errors", name, error_cnt - errors_before);
    end
  endtask

  // Whole table back-to-back under one ready mode
  task automatic run_stream(input int mode, input bit latency_on);
    @(posedge clk_i);
    ready_mode = mode;
    @(negedge clk_i);
    check_latency = latency_on;
    result_cnt    = 0;
    for (int i = 0; i < NUM_VECTORS; i++) begin
      send_item(i);
    end
    in_valid_i = 1'b0;
    wait_drain();
    check_cnt++;
    if (result_cnt != NUM_VECTORS) begin
      $display("ERROR result count: expected 0x%h, actual 0x%h", NUM_VECTORS, result_cnt);
      error_cnt++;
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    int errors_before;
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    operand_a_i   = '0;
    operand_b_i   = '0;
    operand_c_i   = '0;
    op_i          = OP_FMADD;
    op_mod_i      = 1'b0;
    rnd_mode_i    = RM_RNE;
    in_valid_i    = 1'b0;
    flush_i       = 1'b0;
    out_ready_i   = 1'b1;
    error_cnt     = 0;
    check_cnt     = 0;
    test_cnt      = 0;
    result_cnt    = 0;
    cycle_cnt     = 0;
    drive_idx     = 0;
    check_latency = 1'b0;
    ready_mode    = READY_HIGH;
    lcg_state     = 32'd39;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Idle pipeline right after reset
    errors_before = error_cnt;
    check_cnt += 3;
    if (out_valid_o !== 1'b0) begin
      $display("ERROR out_valid_o after reset: expected 0x0, actual 0x%h", out_valid_o);
      error_cnt++;
    end
    if (busy_o !== 1'b0) begin
      $display("ERROR busy_o after reset: expected 0x0, actual 0x%h", busy_o);
      error_cnt++;
    end
    if (in_ready_o !== 1'b1) begin
      $display("ERROR in_ready_o after reset: expected 0x1, actual 0x%h", in_ready_o);
      error_cnt++;
    end
    end_test("reset_state", errors_before);

    errors_before = error_cnt;
    run_stream(READY_HIGH, 1'b1);
    end_test("table_fixed_latency", errors_before);

    errors_before = error_cnt;
    run_stream(READY_RANDOM, 1'b0);
    end_test("table_random_backpressure", errors_before);

    // Two stalled items are dropped by a flush
    errors_before = error_cnt;
    @(posedge clk_i);
    ready_mode = READY_LOW;
    @(negedge clk_i);
    check_latency = 1'b0;
    send_item(0);
    send_item(1);
    // Both stages full and stalled
    check_cnt++;
    if (in_ready_o !== 1'b0) begin
      $display("ERROR in_ready_o with full pipeline: expected 0x0, actual 0x%h", in_ready_o);
      error_cnt++;
    end
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    check_cnt++;
    if (busy_o !== 1'b0) begin
      $display("ERROR busy_o after flush: expected 0x0, actual 0x%h", busy_o);
      error_cnt++;
    end
    @(posedge clk_i);
    ready_mode = READY_HIGH;
    repeat (6) begin
      @(negedge clk_i);
      check_cnt++;
      if (out_valid_o !== 1'b0) begin
        $display("ERROR out_valid_o after flush: expected 0x0, actual 0x%h", out_valid_o);
        error_cnt++;
      end
    end
    // Fresh item after the flush
    send_item(4);
    in_valid_i = 1'b0;
    wait_drain();
    end_test("flush", errors_before);

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
